// File: Makefile
# Verilator build and run of the pixel accelerator testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the run log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module pel_accel_tb -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)

// File: logic/pel_accel_top.sv
module pel_accel_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Register bus
  input  logic                  reg_we_i,
  input  pel_pkg::reg_addr_t    reg_addr_i,
  input  pel_pkg::reg_data_t    reg_wdata_i,
  output pel_pkg::reg_data_t    reg_rdata_o,
  // Pixel and size streams
  input  pel_pkg::pel_stream_t  in_pel_i,
  output logic                  in_pel_ready_o,
  input  pel_pkg::size_stream_t in_size_i,
  output logic                  in_size_ready_o,
  output pel_pkg::pel_stream_t  out_pel_o,
  input  logic                  out_pel_ready_i
);

  pel_pkg::ctrl_engine_t  ctrl;
  pel_pkg::flags_engine_t flags;

  // Software-facing registers
  pel_cfg_regs i_pel_cfg_regs (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_rdata_o ( reg_rdata_o ),
    .flags_i     ( flags       ),
    .ctrl_o      ( ctrl        )
  );

  // Streaming datapath
  pel_engine i_pel_engine (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .ctrl_i          ( ctrl            ),
    .in_pel_i        ( in_pel_i        ),
    .in_pel_ready_o  ( in_pel_ready_o  ),
    .in_size_i       ( in_size_i       ),
    .in_size_ready_o ( in_size_ready_o ),
    .out_pel_o       ( out_pel_o       ),
    .out_pel_ready_i ( out_pel_ready_i ),
    .flags_o         ( flags           )
  );

endmodule

// File: logic/pel_cfg_regs.sv
`include "pel_defs.svh"

module pel_cfg_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   reg_we_i,
  input  pel_pkg::reg_addr_t     reg_addr_i,
  input  pel_pkg::reg_data_t     reg_wdata_i,
  output pel_pkg::reg_data_t     reg_rdata_o,
  input  pel_pkg::flags_engine_t flags_i,
  output pel_pkg::ctrl_engine_t  ctrl_o
);

  // Register map
  localparam pel_pkg::reg_addr_t ADDR_CTRL   = 2'd0;
  localparam pel_pkg::reg_addr_t ADDR_KERNEL = 2'd1;
  localparam pel_pkg::reg_addr_t ADDR_PARAM  = 2'd2;
  localparam pel_pkg::reg_addr_t ADDR_STATUS = 2'd3;

  pel_pkg::kernel_id_t kernel_id_q;
  pel_pkg::pel_t       param_q;
  logic                start_q;
  logic                clear_q;
  logic                done_sticky_q;
  logic                ctrl_wr;
  pel_pkg::reg_data_t  status;

  assign ctrl_wr = reg_we_i && (reg_addr_i == ADDR_CTRL);

  // Kernel configuration
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kernel_id_q <= '0;
      param_q     <= '0;
    end else if (reg_we_i) begin
      if (reg_addr_i == ADDR_KERNEL) begin
        kernel_id_q <= reg_wdata_i[1:0];
      end
      if (reg_addr_i == ADDR_PARAM) begin
        param_q <= reg_wdata_i[`PEL_W-1:0];
      end
    end
  end

  // One-cycle command pulses
  // Clear wins when both bits are written together
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q <= 1'b0;
      clear_q <= 1'b0;
    end else begin
      start_q <= ctrl_wr && reg_wdata_i[0] && !reg_wdata_i[1];
      clear_q <= ctrl_wr && reg_wdata_i[1];
    end
  end

  // Sticky done, held until the next start or clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_sticky_q <= 1'b0;
    end else if (start_q || clear_q) begin
      done_sticky_q <= 1'b0;
    end else if (flags_i.done) begin
      done_sticky_q <= 1'b1;
    end
  end

  // STATUS word
  always_comb begin
    status                 = '0;
    status[0]              = flags_i.ready;
    status[1]              = done_sticky_q;
    status[16 +: `CNT_W]   = flags_i.cnt;
  end

  // Read mux, CTRL reads back zero
  always_comb begin
    case (reg_addr_i)
      ADDR_KERNEL: reg_rdata_o = pel_pkg::reg_data_t'(kernel_id_q);
      ADDR_PARAM:  reg_rdata_o = pel_pkg::reg_data_t'(param_q);
      ADDR_STATUS: reg_rdata_o = status;
      default:     reg_rdata_o = '0;
    endcase
  end

  assign ctrl_o.start     = start_q;
  assign ctrl_o.clear     = clear_q;
  assign ctrl_o.kernel_id = kernel_id_q;
  assign ctrl_o.param     = param_q;

  // Engine must never see both commands at once
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(ctrl_o.start && ctrl_o.clear))
    else $error("start and clear pulsed in the same cycle");

endmodule

// File: logic/pel_defs.svh
`ifndef PEL_DEFS_SVH
`define PEL_DEFS_SVH

// Pixel width in bits
`define PEL_W 8

// Job length width
`define SIZE_W 16

// Output pixel counter width
`define CNT_W 16

// Register bus address width
`define REG_AW 2

// Register bus data width
`define REG_DW 32

`endif

// File: logic/pel_engine.sv
module pel_engine (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  pel_pkg::ctrl_engine_t  ctrl_i,
  input  pel_pkg::pel_stream_t   in_pel_i,
  output logic                   in_pel_ready_o,
  input  pel_pkg::size_stream_t  in_size_i,
  output logic                   in_size_ready_o,
  output pel_pkg::pel_stream_t   out_pel_o,
  input  logic                   out_pel_ready_i,
  output pel_pkg::flags_engine_t flags_o
);

  logic          adp_done;
  logic          adp_idle;
  logic          ready_q;
  pel_pkg::cnt_t cnt_q;
  logic          out_fire;

  // Ready lags adapter idle by one cycle
  // Stays low through the reset cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= adp_idle;
    end
  end

  // Accepted output pixels
  assign out_fire = out_pel_o.valid && out_pel_ready_i;

  // Restarted by start and by clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (ctrl_i.start || ctrl_i.clear) begin
      cnt_q <= '0;
    end else if (out_fire) begin
      cnt_q <= cnt_q + pel_pkg::cnt_t'(1);
    end
  end

  assign flags_o.ready = ready_q;
  assign flags_o.done  = adp_done;
  assign flags_o.cnt   = cnt_q;

  // Job sequencing and kernels
  pel_kernel_adapter i_pel_kernel_adapter (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .ctrl_i          ( ctrl_i          ),
    .in_pel_i        ( in_pel_i        ),
    .in_pel_ready_o  ( in_pel_ready_o  ),
    .in_size_i       ( in_size_i       ),
    .in_size_ready_o ( in_size_ready_o ),
    .out_pel_o       ( out_pel_o       ),
    .out_pel_ready_i ( out_pel_ready_i ),
    .done_o          ( adp_done        ),
    .idle_o          ( adp_idle        )
  );

endmodule

// File: logic/pel_kernel_adapter.sv
`include "pel_defs.svh"

module pel_kernel_adapter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pel_pkg::ctrl_engine_t ctrl_i,
  input  pel_pkg::pel_stream_t  in_pel_i,
  output logic                  in_pel_ready_o,
  input  pel_pkg::size_stream_t in_size_i,
  output logic                  in_size_ready_o,
  output pel_pkg::pel_stream_t  out_pel_o,
  input  logic                  out_pel_ready_i,
  output logic                  done_o,
  output logic                  idle_o
);

  pel_pkg::adapter_state_e state_q;
  pel_pkg::adapter_state_e state_d;
  pel_pkg::size_t          pix_left_q;
  pel_pkg::size_t          out_left_q;
  pel_pkg::kernel_id_t     kernel_q;
  pel_pkg::pel_t           param_q;
  logic                    out_valid_q;
  pel_pkg::pel_t           out_data_q;
  pel_pkg::pel_t           kernel_res;
  logic [`PEL_W:0]         sum_wide;
  logic                    size_fire;
  logic                    in_fire;
  logic                    out_fire;

  // Handshakes
  assign in_size_ready_o = (state_q == pel_pkg::ADP_SIZE);
  // Accept while the output stage is free or draining this cycle
  assign in_pel_ready_o  = (state_q == pel_pkg::ADP_RUN) && (pix_left_q != '0) &&
                           (!out_valid_q || out_pel_ready_i);

  assign size_fire = in_size_i.valid && in_size_ready_o;
  assign in_fire   = in_pel_i.valid && in_pel_ready_o;
  assign out_fire  = out_valid_q && out_pel_ready_i;

  // Job FSM
  always_comb begin
    state_d = state_q;
    case (state_q)
      pel_pkg::ADP_IDLE: begin
        if (ctrl_i.start) begin
          state_d = pel_pkg::ADP_SIZE;
        end
      end
      pel_pkg::ADP_SIZE: begin
        // Empty job skips the run phase
        if (size_fire) begin
          state_d = (in_size_i.data == '0) ? pel_pkg::ADP_DONE : pel_pkg::ADP_RUN;
        end
      end
      pel_pkg::ADP_RUN: begin
        if (out_fire && (out_left_q == pel_pkg::size_t'(1))) begin
          state_d = pel_pkg::ADP_DONE;
        end
      end
      default: begin
        state_d = pel_pkg::ADP_IDLE;
      end
    endcase
    // Clear aborts from anywhere
    if (ctrl_i.clear) begin
      state_d = pel_pkg::ADP_IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= pel_pkg::ADP_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Remaining input and output pixels
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pix_left_q <= '0;
      out_left_q <= '0;
    end else if (ctrl_i.clear) begin
      pix_left_q <= '0;
      out_left_q <= '0;
    end else if (size_fire) begin
      pix_left_q <= in_size_i.data;
      out_left_q <= in_size_i.data;
    end else begin
      if (in_fire) begin
        pix_left_q <= pix_left_q - pel_pkg::size_t'(1);
      end
      if (out_fire) begin
        out_left_q <= out_left_q - pel_pkg::size_t'(1);
      end
    end
  end

  // Kernel settings frozen for the whole job
  always_ff @(posedge clk_i) begin
    if ((state_q == pel_pkg::ADP_IDLE) && ctrl_i.start) begin
      kernel_q <= ctrl_i.kernel_id;
      param_q  <= ctrl_i.param;
    end
  end

  // Per-pixel kernels
  assign sum_wide = {1'b0, in_pel_i.data} + {1'b0, param_q};

  always_comb begin
    case (kernel_q)
      2'd0: kernel_res = in_pel_i.data;
      2'd1: kernel_res = '1 - in_pel_i.data;
      2'd2: kernel_res = (in_pel_i.data >= param_q) ? '1 : '0;
      // Saturate on carry out
      default: kernel_res = sum_wide[`PEL_W] ? '1 : sum_wide[`PEL_W-1:0];
    endcase
  end

  // Output stage valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (ctrl_i.clear) begin
      out_valid_q <= 1'b0;
    end else if (in_fire) begin
      out_valid_q <= 1'b1;
    end else if (out_fire) begin
      out_valid_q <= 1'b0;
    end
  end

  // Output stage data
  always_ff @(posedge clk_i) begin
    if (in_fire) begin
      out_data_q <= kernel_res;
    end
  end

  assign out_pel_o.valid = out_valid_q;
  assign out_pel_o.data  = out_data_q;
  assign done_o          = (state_q == pel_pkg::ADP_DONE);
  assign idle_o          = (state_q == pel_pkg::ADP_IDLE);

  // Stalled output must hold
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_valid_q && !out_pel_ready_i && !ctrl_i.clear |=> out_valid_q && $stable(out_data_q))
    else $error("out_pel changed while stalled");

  // Register block only starts an idle adapter
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ctrl_i.start |-> state_q == pel_pkg::ADP_IDLE)
    else $error("start received while a job is running");

endmodule

// File: logic/pel_pkg.sv
`include "pel_defs.svh"

package pel_pkg;

  // Vectors with a meaning of their own
  typedef logic [`PEL_W-1:0]  pel_t;
  typedef logic [`SIZE_W-1:0] size_t;
  typedef logic [`CNT_W-1:0]  cnt_t;
  typedef logic [1:0]         kernel_id_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`REG_DW-1:0] reg_data_t;

  // Adapter job FSM
  typedef enum logic [1:0] {
    ADP_IDLE,
    ADP_SIZE,
    ADP_RUN,
    ADP_DONE
  } adapter_state_e;

  // Register block to engine
  typedef struct packed {
    logic       start;
    logic       clear;
    kernel_id_t kernel_id;
    pel_t       param;
  } ctrl_engine_t;

  // Engine back to register block
  typedef struct packed {
    logic ready;
    logic done;
    cnt_t cnt;
  } flags_engine_t;

  // Pixel stream forward half, ready runs back on its own wire
  typedef struct packed {
    logic valid;
    pel_t data;
  } pel_stream_t;

  // Size stream forward half
  typedef struct packed {
    logic  valid;
    size_t data;
  } size_stream_t;

endpackage

// File: src.f
+incdir+logic
logic/pel_pkg.sv
logic/pel_cfg_regs.sv
logic/pel_kernel_adapter.sv
logic/pel_engine.sv
logic/pel_accel_top.sv
verif/pel_accel_tb.sv

// File: verif/pel_accel_tb.sv
module pel_accel_tb;

  // Register map
  localparam pel_pkg::reg_addr_t ADDR_CTRL   = 2'd0;
  localparam pel_pkg::reg_addr_t ADDR_KERNEL = 2'd1;
  localparam pel_pkg::reg_addr_t ADDR_PARAM  = 2'd2;
  localparam pel_pkg::reg_addr_t ADDR_STATUS = 2'd3;

  // Percent of cycles with an input gap or an output stall
  localparam int STALL_PCT = 30;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  reg_we;
  pel_pkg::reg_addr_t    reg_addr;
  pel_pkg::reg_data_t    reg_wdata;
  pel_pkg::reg_data_t    reg_rdata;
  pel_pkg::pel_stream_t  in_pel;
  logic                  in_pel_ready;
  pel_pkg::size_stream_t in_size;
  logic                  in_size_ready;
  pel_pkg::pel_stream_t  out_pel;
  logic                  out_pel_ready;

  // Parsed cases with one entry per job
  int job_kernel[$];
  int job_param[$];
  int job_size[$];
  int job_first[$];
  int job_npix[$];
  int job_clear[$];
  // One entry per pixel line
  int pix_in[$];
  int pix_exp[$];

  int cycle_cnt = 0;
  int cycle_limit = 0;

  always #5 clk = ~clk;

  pel_accel_top pel_accel_top_i (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .reg_we_i        ( reg_we        ),
    .reg_addr_i      ( reg_addr      ),
    .reg_wdata_i     ( reg_wdata     ),
    .reg_rdata_o     ( reg_rdata     ),
    .in_pel_i        ( in_pel        ),
    .in_pel_ready_o  ( in_pel_ready  ),
    .in_size_i       ( in_size       ),
    .in_size_ready_o ( in_size_ready ),
    .out_pel_o       ( out_pel       ),
    .out_pel_ready_i ( out_pel_ready )
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch at time %0t: %s got 0x%0h expected 0x%0h",
                         $time, name, actual, expected));
    end
  endtask

  // Run limit stretched by the amount of work in the cases file
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      fail_run($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
  end

  task automatic load_cases();
    int         fd;
    int         c;
    int         n;
    int         a;
    int         b;
    int         s;
    int         j;
    logic [7:0] ch;
    fd = $fopen("verif/pel_cases.txt", "r");
    if (fd == 0) begin
      fail_run("could not open verif/pel_cases.txt");
    end
    c = $fgetc(fd);
    while (c != -1) begin
      ch = c[7:0];
      if (ch == "#") begin
        // Skip to end of line
        while (c != -1 && c[7:0] != "\n") begin
          c = $fgetc(fd);
        end
      end else if (ch == "J") begin
        n = $fscanf(fd, "%d %d %d", a, b, s);
        if (n != 3) begin
          fail_run("job line in cases file has missing fields");
        end
        job_kernel.push_back(a);
        job_param.push_back(b);
        job_size.push_back(s);
        job_first.push_back(pix_in.size());
        job_npix.push_back(0);
        job_clear.push_back(0);
      end else if (ch == "P") begin
        n = $fscanf(fd, "%d %d", a, b);
        if (n != 2 || job_npix.size() == 0) begin
          fail_run("pixel line in cases file is malformed or has no job");
        end
        pix_in.push_back(a);
        pix_exp.push_back(b);
        job_npix[job_npix.size() - 1] = job_npix[job_npix.size() - 1] + 1;
      end else if (ch == "C") begin
        if (job_clear.size() == 0) begin
          fail_run("clear line in cases file comes before any job");
        end
        job_clear[job_clear.size() - 1] = 1;
      end else if (ch != " " && ch != "\n" && ch != "\t" && ch != 8'h0d) begin
        fail_run("unexpected character in cases file");
      end
      c = $fgetc(fd);
    end
    $fclose(fd);
    // Full jobs list every pixel and cut jobs fewer than their size
    for (j = 0; j < job_size.size(); j++) begin
      if ((job_clear[j] == 0 && job_npix[j] != job_size[j]) ||
          (job_clear[j] != 0 && job_npix[j] >= job_size[j])) begin
        fail_run($sformatf("job %0d in cases file has a wrong number of pixels", j));
      end
    end
  endtask

  task automatic reg_write(input pel_pkg::reg_addr_t addr, input pel_pkg::reg_data_t data);
    @(negedge clk);
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_we    = 1'b0;
  endtask

  // Combinational read data sampled once settled
  task automatic reg_read(input pel_pkg::reg_addr_t addr, output pel_pkg::reg_data_t data);
    @(negedge clk);
    reg_addr = addr;
    #1;
    data = reg_rdata;
  endtask

  task automatic check_status(input int ready, input int done, input int count);
    pel_pkg::reg_data_t st;
    reg_read(ADDR_STATUS, st);
    check_value("status.ready", 32'(st[0]), 32'(ready));
    check_value("status.done", 32'(st[1]), 32'(done));
    check_value("status.count", 32'(st[31:16]), 32'(count));
  endtask

  // Streams quiet while the engine is idle
  task automatic check_streams_idle();
    check_value("in_size_ready_o", 32'(in_size_ready), 32'd0);
    check_value("in_pel_ready_o", 32'(in_pel_ready), 32'd0);
    check_value("out_pel_o.valid", 32'(out_pel.valid), 32'd0);
  endtask

  // Poll one STATUS bit until set
  task automatic poll_status(input int bit_idx);
    pel_pkg::reg_data_t st;
    st = '0;
    while (st[bit_idx] !== 1'b1) begin
      reg_read(ADDR_STATUS, st);
    end
  endtask

  task automatic send_size(input int size);
    logic accepted;
    @(negedge clk);
    in_size.valid = 1'b1;
    in_size.data  = pel_pkg::size_t'(size);
    accepted = 1'b0;
    while (!accepted) begin
      #1;
      accepted = in_size_ready;
      if (!accepted) begin
        @(negedge clk);
      end
    end
    // Transfer on the rising edge in between
    @(negedge clk);
    in_size.valid = 1'b0;
  endtask

  task automatic feed_pixels(input int first, input int count);
    int   i;
    logic accepted;
    for (i = 0; i < count; i++) begin
      @(negedge clk);
      // Random idle cycles before the next pixel
      while ($urandom_range(99, 0) < STALL_PCT) begin
        in_pel.valid = 1'b0;
        @(negedge clk);
      end
      in_pel.valid = 1'b1;
      in_pel.data  = pel_pkg::pel_t'(pix_in[first + i]);
      accepted = 1'b0;
      while (!accepted) begin
        #1;
        accepted = in_pel_ready;
        if (!accepted) begin
          @(negedge clk);
        end
      end
      @(posedge clk);
    end
    @(negedge clk);
    in_pel.valid = 1'b0;
  endtask

  // Output order must match input order
  task automatic collect_pixels(input int first, input int count);
    int   i;
    logic got;
    for (i = 0; i < count; i++) begin
      got = 1'b0;
      while (!got) begin
        @(negedge clk);
        out_pel_ready = ($urandom_range(99, 0) >= STALL_PCT);
        #1;
        got = out_pel.valid && out_pel_ready;
      end
      check_value("out_pel_o.data", 32'(out_pel.data), 32'(pix_exp[first + i]));
      @(posedge clk);
    end
    @(negedge clk);
    out_pel_ready = 1'b0;
  endtask

  task automatic run_job(input int j);
    pel_pkg::reg_data_t rd;
    reg_write(ADDR_KERNEL, pel_pkg::reg_data_t'(job_kernel[j]));
    reg_write(ADDR_PARAM, pel_pkg::reg_data_t'(job_param[j]));
    reg_read(ADDR_KERNEL, rd);
    check_value("kernel_id", rd, 32'(job_kernel[j]));
    reg_read(ADDR_PARAM, rd);
    check_value("param", rd, 32'(job_param[j]));
    reg_write(ADDR_CTRL, 32'd1);
    send_size(job_size[j]);
    fork
      feed_pixels(job_first[j], job_npix[j]);
      collect_pixels(job_first[j], job_npix[j]);
    join
    if (job_clear[j] != 0) begin
      // Job still running with pixels outstanding
      check_status(0, 0, job_npix[j]);
      reg_write(ADDR_CTRL, 32'd2);
      poll_status(0);
      check_status(1, 0, 0);
    end else begin
      poll_status(1);
      check_status(1, 1, job_size[j]);
    end
    // No stray output or handshake after the job
    check_streams_idle();
  endtask

  initial begin
    int j;
    void'($urandom(98806));
    rst_n         = 1'b0;
    reg_we        = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    in_pel        = '0;
    in_size       = '0;
    out_pel_ready = 1'b0;
    load_cases();
    cycle_limit = 20 * pix_in.size() + 50 * job_kernel.size();
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    // Idle after reset
    check_status(1, 0, 0);
    check_streams_idle();
    for (j = 0; j < job_kernel.size(); j++) begin
      run_job(j);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verif/pel_cases.txt
# J kernel param size, followed by one line per pixel: P input expected
# C cuts the job above short with a clear after the pixels listed so far
J 0 0 4
P 0 0
P 17 17
P 128 128
P 255 255
J 1 0 4
P 0 255
P 1 254
P 100 155
P 255 0
J 2 128 4
P 127 0
P 128 255
P 200 255
P 5 0
J 2 0 2
P 0 255
P 77 255
J 2 255 3
P 254 0
P 255 255
P 0 0
J 3 10 4
P 0 10
P 100 110
P 245 255
P 250 255
J 3 255 2
P 0 255
P 1 255
J 0 0 0
J 1 0 6
P 10 245
P 20 235
P 30 225
C
J 3 50 3
P 200 250
P 205 255
P 60 110
